//--- hdl/alu_unit.sv
/*
 * Single-cycle ALU. Registers the result of an issued instruction onto the
 * completion bus and flags branches whose outcome contradicts the prediction.
 */
`timescale 1ns/1ps

module alu_unit (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            squash,
    input  logic                            issue_valid,
    input  ooo_pkg::alu_op_t                issue_op,
    input  logic [ooo_pkg::xlen-1:0]        issue_a,
    input  logic [ooo_pkg::xlen-1:0]        issue_b,
    input  logic                            issue_predict,
    input  logic [ooo_pkg::rob_idx_len-1:0] issue_tag,
    output logic                            complete_valid,
    output logic [ooo_pkg::rob_idx_len-1:0] complete_tag,
    output logic [ooo_pkg::xlen-1:0]        complete_value,
    output logic                            complete_mis_pred
);
    import ooo_pkg::*;

    logic [xlen-1:0] result;
    logic            mis_pred;

    always_comb begin
        result = '0;
        mis_pred = 1'b0;
        case (issue_op)
            op_add: result = issue_a + issue_b;
            op_sub: result = issue_a - issue_b;
            op_xor: result = issue_a ^ issue_b;
            op_branch: mis_pred = (issue_a == issue_b) != issue_predict; // Taken when equal.
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            complete_valid <= 1'b0;  // A result computed under squash is dropped.
        end else begin
            complete_valid <= issue_valid;
        end
        complete_tag <= issue_tag;
        complete_value <= result;
        complete_mis_pred <= mis_pred;
    end

endmodule

//--- hdl/arch_regfile.sv
/*
 * Committed register file with two read ports and the retire write port.
 * Register i comes out of reset holding i.
 */
`timescale 1ns/1ps

module arch_regfile (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [ooo_pkg::reg_idx_len-1:0] read_reg1,
    input  logic [ooo_pkg::reg_idx_len-1:0] read_reg2,
    input  logic                            write_enable,
    input  logic [ooo_pkg::reg_idx_len-1:0] write_reg,
    input  logic [ooo_pkg::xlen-1:0]        write_value,
    output logic [ooo_pkg::xlen-1:0]        read_value1,
    output logic [ooo_pkg::xlen-1:0]        read_value2
);
    import ooo_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    assign read_value1 = (read_reg1 == '0) ? '0 : regs[read_reg1];
    assign read_value2 = (read_reg2 == '0) ? '0 : regs[read_reg2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= xlen'(i);
            end
        end else if (write_enable && (write_reg != '0)) begin
            regs[write_reg] <= write_value;
        end
    end

endmodule

//--- hdl/map_table.sv
/*
 * Rename table. Maps each architectural register to the reorder buffer tag
 * of its newest writer in flight; register zero is never renamed.
 */
`timescale 1ns/1ps

module map_table (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            dispatch_enable,
    input  logic [ooo_pkg::reg_idx_len-1:0] dest_reg,
    input  logic [ooo_pkg::rob_idx_len-1:0] rob_tail,
    input  logic [ooo_pkg::reg_idx_len-1:0] src_reg1,
    input  logic [ooo_pkg::reg_idx_len-1:0] src_reg2,
    input  logic                            retire_valid,
    input  logic [ooo_pkg::reg_idx_len-1:0] retire_reg,
    input  logic [ooo_pkg::rob_idx_len-1:0] retire_tag,
    input  logic                            squash,
    output logic                            src_busy1,
    output logic                            src_busy2,
    output logic [ooo_pkg::rob_idx_len-1:0] src_tag1,
    output logic [ooo_pkg::rob_idx_len-1:0] src_tag2
);
    import ooo_pkg::*;

    logic [reg_count-1:0]   map_busy;
    logic [rob_idx_len-1:0] map_tag [reg_count];
    logic                   retire_clear;

    // Sources see the mapping from before this cycle's dispatch.
    assign src_busy1 = map_busy[src_reg1];
    assign src_busy2 = map_busy[src_reg2];
    assign src_tag1 = map_tag[src_reg1];
    assign src_tag2 = map_tag[src_reg2];

    // Only the newest writer may release a register, and not if it is remapped now.
    assign retire_clear = retire_valid && map_busy[retire_reg]
                          && (map_tag[retire_reg] == retire_tag)
                          && !(dispatch_enable && (dest_reg == retire_reg));

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            map_busy <= '0;
        end else begin
            if (retire_clear) begin
                map_busy[retire_reg] <= 1'b0;
            end
            if (dispatch_enable && (dest_reg != '0)) begin
                map_busy[dest_reg] <= 1'b1;
                map_tag[dest_reg] <= rob_tail;
            end
        end
    end

endmodule

//--- hdl/ooo_core.sv
/*
 * Top of the out-of-order back end. Wires the rename table, reorder buffer,
 * reservation station, ALU and register file behind the dispatch and retire ports.
 */
`timescale 1ns/1ps

module ooo_core (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            dispatch_enable,
    input  ooo_pkg::alu_op_t                op,
    input  logic [ooo_pkg::reg_idx_len-1:0] dest_reg,
    input  logic [ooo_pkg::reg_idx_len-1:0] src_reg1,
    input  logic [ooo_pkg::reg_idx_len-1:0] src_reg2,
    input  logic                            predict_taken,
    output logic                            dispatch_stall,
    output logic                            retire_valid,
    output logic [ooo_pkg::reg_idx_len-1:0] retire_reg,
    output logic [ooo_pkg::xlen-1:0]        retire_value,
    output logic                            squash
);
    import ooo_pkg::*;

    logic [reg_idx_len-1:0] alloc_dest;
    logic [rob_idx_len-1:0] rob_tail, retire_tag;
    logic                   rob_full, rs_full;
    logic                   src_busy1, src_busy2;
    logic [rob_idx_len-1:0] src_tag1, src_tag2;
    logic                   rob_ready1, rob_ready2;
    logic [xlen-1:0]        rob_value1, rob_value2;
    logic [xlen-1:0]        rf_value1, rf_value2;
    logic                   operand_ready1, operand_ready2;
    logic [xlen-1:0]        operand_value1, operand_value2;
    logic                   issue_valid, issue_predict;
    alu_op_t                issue_op;
    logic [xlen-1:0]        issue_a, issue_b;
    logic [rob_idx_len-1:0] issue_tag;
    logic                   complete_valid, complete_mis_pred;
    logic [rob_idx_len-1:0] complete_tag;
    logic [xlen-1:0]        complete_value;

    assign dispatch_stall = rob_full || rs_full || squash;
    assign alloc_dest = (op == op_branch) ? '0 : dest_reg;  // Branches write nothing.

    // A renamed source takes the reorder buffer value once it is ready.
    assign operand_ready1 = !src_busy1 || rob_ready1;
    assign operand_ready2 = !src_busy2 || rob_ready2;
    assign operand_value1 = src_busy1 ? rob_value1 : rf_value1;
    assign operand_value2 = src_busy2 ? rob_value2 : rf_value2;

    map_table u_map (
        .clock, .reset, .dispatch_enable, .dest_reg(alloc_dest), .rob_tail,
        .src_reg1, .src_reg2, .retire_valid, .retire_reg, .retire_tag, .squash,
        .src_busy1, .src_busy2, .src_tag1, .src_tag2
    );

    reorder_buffer u_rob (
        .clock, .reset, .dispatch_enable, .dispatch_dest(alloc_dest),
        .read_tag1(src_tag1), .read_tag2(src_tag2),
        .complete_valid, .complete_tag, .complete_value, .complete_mis_pred,
        .rob_tail, .rob_full, .read_ready1(rob_ready1), .read_ready2(rob_ready2),
        .read_value1(rob_value1), .read_value2(rob_value2),
        .retire_valid, .retire_reg, .retire_value, .retire_tag, .squash
    );

    reservation_station u_rs (
        .clock, .reset, .squash, .dispatch_enable, .op, .predict_taken, .rob_tail,
        .operand_ready1, .operand_value1, .operand_tag1(src_tag1),
        .operand_ready2, .operand_value2, .operand_tag2(src_tag2),
        .complete_valid, .complete_tag, .complete_value,
        .rs_full, .issue_valid, .issue_op, .issue_a, .issue_b, .issue_predict, .issue_tag
    );

    alu_unit u_alu (
        .clock, .reset, .squash, .issue_valid, .issue_op, .issue_a, .issue_b,
        .issue_predict, .issue_tag,
        .complete_valid, .complete_tag, .complete_value, .complete_mis_pred
    );

    arch_regfile u_regs (
        .clock, .reset, .read_reg1(src_reg1), .read_reg2(src_reg2),
        .write_enable(retire_valid), .write_reg(retire_reg), .write_value(retire_value),
        .read_value1(rf_value1), .read_value2(rf_value2)
    );

endmodule

//--- hdl/ooo_pkg.sv
/*
 * Shared sizes, operation codes and the reorder buffer entry for the
 * out-of-order core. Modules import it inside their bodies.
 */
package ooo_pkg;

    localparam int xlen = 32;             // Data word width.
    localparam int reg_count = 32;
    localparam int reg_idx_len = 5;
    localparam int rob_size = 8;
    localparam int rob_idx_len = 3;
    localparam int rs_size = 4;
    localparam int rs_idx_len = 2;        // Also the width of an entry age.

    // Operations that reach the dispatch port already decoded.
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_branch
    } alu_op_t;

    // One slot of the reorder buffer.
    typedef struct packed {
        logic                   busy;     // Slot holds an instruction in flight.
        logic                   ready;    // Result has been completed.
        logic [reg_idx_len-1:0] dest_reg; // Zero for a branch.
        logic [xlen-1:0]        value;
        logic                   mis_pred;
    } rob_entry_t;

endpackage

//--- hdl/reorder_buffer.sv
/*
 * Circular reorder buffer. Allocates tags at the tail, records ALU completions,
 * serves operand reads by tag and retires the head in program order.
 */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            dispatch_enable,
    input  logic [ooo_pkg::reg_idx_len-1:0] dispatch_dest,
    input  logic [ooo_pkg::rob_idx_len-1:0] read_tag1,
    input  logic [ooo_pkg::rob_idx_len-1:0] read_tag2,
    input  logic                            complete_valid,
    input  logic [ooo_pkg::rob_idx_len-1:0] complete_tag,
    input  logic [ooo_pkg::xlen-1:0]        complete_value,
    input  logic                            complete_mis_pred,
    output logic [ooo_pkg::rob_idx_len-1:0] rob_tail,
    output logic                            rob_full,
    output logic                            read_ready1,
    output logic                            read_ready2,
    output logic [ooo_pkg::xlen-1:0]        read_value1,
    output logic [ooo_pkg::xlen-1:0]        read_value2,
    output logic                            retire_valid,
    output logic [ooo_pkg::reg_idx_len-1:0] retire_reg,
    output logic [ooo_pkg::xlen-1:0]        retire_value,
    output logic [ooo_pkg::rob_idx_len-1:0] retire_tag,
    output logic                            squash
);
    import ooo_pkg::*;

    rob_entry_t             entries [rob_size];
    logic [rob_idx_len-1:0] rob_head;
    logic [rob_idx_len:0]   rob_count;    // One bit wider so full differs from empty.
    logic                   bypass1;
    logic                   bypass2;

    assign rob_full = (rob_count == rob_size);

    // A result on the completion bus this cycle counts as ready already.
    assign bypass1 = complete_valid && (complete_tag == read_tag1);
    assign bypass2 = complete_valid && (complete_tag == read_tag2);

    assign read_ready1 = entries[read_tag1].ready || bypass1;
    assign read_ready2 = entries[read_tag2].ready || bypass2;
    assign read_value1 = bypass1 ? complete_value : entries[read_tag1].value;
    assign read_value2 = bypass2 ? complete_value : entries[read_tag2].value;

    assign retire_valid = entries[rob_head].busy && entries[rob_head].ready;
    assign retire_reg = entries[rob_head].dest_reg;
    assign retire_value = entries[rob_head].value;
    assign retire_tag = rob_head;
    assign squash = retire_valid && entries[rob_head].mis_pred;

    always_ff @(posedge clock) begin
        if (reset) begin
            rob_head <= '0;
            rob_tail <= '0;
            rob_count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else if (squash) begin
            // Everything younger than the branch is discarded.
            rob_head <= rob_tail;
            rob_count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            if (dispatch_enable) begin
                entries[rob_tail] <= '{busy: 1'b1, ready: 1'b0, dest_reg: dispatch_dest,
                                       value: '0, mis_pred: 1'b0};
                rob_tail <= rob_tail + 1'b1;  // Wraps naturally, the size is a power of two.
            end
            if (complete_valid) begin
                entries[complete_tag].ready <= 1'b1;
                entries[complete_tag].value <= complete_value;
                entries[complete_tag].mis_pred <= complete_mis_pred;
            end
            if (retire_valid) begin
                entries[rob_head].busy <= 1'b0;
                rob_head <= rob_head + 1'b1;
            end
            case ({dispatch_enable, retire_valid})
                2'b10: rob_count <= rob_count + 1'b1;
                2'b01: rob_count <= rob_count - 1'b1;
                default: rob_count <= rob_count;
            endcase
        end
    end

    no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset) dispatch_enable |-> !rob_full);

    // A late completion for a squashed or retired slot would corrupt a reused tag.
    complete_hits_busy: assert property (
        @(posedge clock) disable iff (reset) complete_valid |-> entries[complete_tag].busy);

    count_in_range: assert property (
        @(posedge clock) disable iff (reset) rob_count <= rob_size);

endmodule

//--- hdl/reservation_station.sv
/*
 * Four-entry reservation station. Holds dispatched instructions until both
 * operands are present, snooping the completion bus, and issues the oldest ready one.
 */
`timescale 1ns/1ps

module reservation_station (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            squash,
    input  logic                            dispatch_enable,
    input  ooo_pkg::alu_op_t                op,
    input  logic                            predict_taken,
    input  logic [ooo_pkg::rob_idx_len-1:0] rob_tail,
    input  logic                            operand_ready1,
    input  logic [ooo_pkg::xlen-1:0]        operand_value1,
    input  logic [ooo_pkg::rob_idx_len-1:0] operand_tag1,
    input  logic                            operand_ready2,
    input  logic [ooo_pkg::xlen-1:0]        operand_value2,
    input  logic [ooo_pkg::rob_idx_len-1:0] operand_tag2,
    input  logic                            complete_valid,
    input  logic [ooo_pkg::rob_idx_len-1:0] complete_tag,
    input  logic [ooo_pkg::xlen-1:0]        complete_value,
    output logic                            rs_full,
    output logic                            issue_valid,
    output ooo_pkg::alu_op_t                issue_op,
    output logic [ooo_pkg::xlen-1:0]        issue_a,
    output logic [ooo_pkg::xlen-1:0]        issue_b,
    output logic                            issue_predict,
    output logic [ooo_pkg::rob_idx_len-1:0] issue_tag
);
    import ooo_pkg::*;

    logic [rs_size-1:0]     entry_valid;
    alu_op_t                entry_op [rs_size];
    logic                   entry_predict [rs_size];
    logic [rob_idx_len-1:0] entry_tag [rs_size];     // Destination tag.
    logic [rs_idx_len-1:0]  entry_age [rs_size];     // Larger means older.
    logic                   entry_ready1 [rs_size];
    logic [xlen-1:0]        entry_value1 [rs_size];
    logic [rob_idx_len-1:0] entry_wait1 [rs_size];
    logic                   entry_ready2 [rs_size];
    logic [xlen-1:0]        entry_value2 [rs_size];
    logic [rob_idx_len-1:0] entry_wait2 [rs_size];
    logic [rs_idx_len-1:0]  issue_idx;
    logic [rs_idx_len-1:0]  free_idx;

    assign rs_full = &entry_valid;

    // Ages are unique among valid entries, so the oldest ready one is well defined.
    always_comb begin
        issue_valid = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (entry_valid[i] && entry_ready1[i] && entry_ready2[i]
                && (!issue_valid || entry_age[i] > entry_age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx = rs_idx_len'(i);
            end
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = rs_idx_len'(i);  // Lowest free slot wins.
            end
        end
    end

    assign issue_op = entry_op[issue_idx];
    assign issue_a = entry_value1[issue_idx];
    assign issue_b = entry_value2[issue_idx];
    assign issue_predict = entry_predict[issue_idx];
    assign issue_tag = entry_tag[issue_idx];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < rs_size; i++) begin
                if (complete_valid && entry_valid[i]) begin
                    if (!entry_ready1[i] && (entry_wait1[i] == complete_tag)) begin
                        entry_ready1[i] <= 1'b1;
                        entry_value1[i] <= complete_value;
                    end
                    if (!entry_ready2[i] && (entry_wait2[i] == complete_tag)) begin
                        entry_ready2[i] <= 1'b1;
                        entry_value2[i] <= complete_value;
                    end
                end
                if (dispatch_enable && entry_valid[i]) begin
                    entry_age[i] <= entry_age[i] + 1'b1;
                end
            end
            if (issue_valid) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            if (dispatch_enable) begin
                entry_valid[free_idx] <= 1'b1;
                entry_age[free_idx] <= '0;
                entry_op[free_idx] <= op;
                entry_predict[free_idx] <= predict_taken;
                entry_tag[free_idx] <= rob_tail;
                entry_ready1[free_idx] <= operand_ready1;
                entry_value1[free_idx] <= operand_value1;
                entry_wait1[free_idx] <= operand_tag1;
                entry_ready2[free_idx] <= operand_ready2;
                entry_value2[free_idx] <= operand_value2;
                entry_wait2[free_idx] <= operand_tag2;
            end
        end
    end

    no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset) dispatch_enable |-> !rs_full);

endmodule

//--- ooo_core.f
hdl/ooo_pkg.sv
hdl/reorder_buffer.sv
hdl/map_table.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/arch_regfile.sv
hdl/ooo_core.sv
tests/ooo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the out-of-order core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f ooo_core.f --top-module ooo_core_tb \
    -o ooo_core_sim > build.log 2>&1 \
    && ./obj_dir/ooo_core_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; }
cat sim.log 2>/dev/null
grep -qF "*** TEST PASSED ***" sim.log 2>/dev/null && exit 0 || exit 1

//--- tests/ooo_core_tb.sv
/*
 * Testbench for the out-of-order core. Dispatches a table of instructions with
 * LFSR pacing and checks the retire stream against an in-order model.
 */
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    typedef struct packed {
        alu_op_t                op;
        logic [reg_idx_len-1:0] dest;
        logic [reg_idx_len-1:0] src1;
        logic [reg_idx_len-1:0] src2;
        logic                   predict;
        logic                   paced;    // Random idle cycles go before this row.
    } row_t;

    logic                   clock;
    logic                   reset;
    logic                   dispatch_enable;
    alu_op_t                op;
    logic [reg_idx_len-1:0] dest_reg;
    logic [reg_idx_len-1:0] src_reg1;
    logic [reg_idx_len-1:0] src_reg2;
    logic                   predict_taken;
    logic                   dispatch_stall;
    logic                   retire_valid;
    logic [reg_idx_len-1:0] retire_reg;
    logic [xlen-1:0]        retire_value;
    logic                   squash;

    row_t            rows[$];
    string           names[$];
    int              pending[$];        // Dispatched rows not yet retired, oldest first.
    logic [xlen-1:0] model_regs [reg_count];
    logic [31:0]     lfsr = 32'hd3c;
    int              errors = 0;
    int              retired = 0;
    int              squashed = 0;
    int              retire_events = 0; // Retire cycles seen on the DUT port.
    int              stall_cycles = 0;  // Cycles held back by a full buffer.

    ooo_core uut (
        .clock, .reset, .dispatch_enable, .op, .dest_reg, .src_reg1, .src_reg2,
        .predict_taken, .dispatch_stall, .retire_valid, .retire_reg, .retire_value, .squash
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int draw_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    task automatic add_row(input string name, input alu_op_t row_op, input int dest,
                           input int src1, input int src2, input bit predict, input bit paced);
        row_t r;
        r.op = row_op;
        r.dest = reg_idx_len'(dest);
        r.src1 = reg_idx_len'(src1);
        r.src2 = reg_idx_len'(src2);
        r.predict = predict;
        r.paced = paced;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", name, what, expected, actual);
            errors++;
        end
    endtask

    // Retirement is in order, so the model registers hold exactly what this row must read.
    task automatic check_retire();
        int                     idx;
        int                     errors_before;
        row_t                   r;
        logic [xlen-1:0]        a;
        logic [xlen-1:0]        b;
        logic [xlen-1:0]        exp_value;
        logic [reg_idx_len-1:0] exp_reg;
        logic                   exp_mis;
        assert (pending.size() != 0) else begin
            $display("Retire of r%0d seen with no instruction outstanding", retire_reg);
            errors++;
        end
        if (pending.size() == 0) return;
        idx = pending.pop_front();
        r = rows[idx];
        errors_before = errors;
        a = model_regs[r.src1];
        b = model_regs[r.src2];
        exp_reg = r.dest;
        exp_mis = 1'b0;
        case (r.op)
            op_add: exp_value = a + b;
            op_sub: exp_value = a - b;
            op_xor: exp_value = a ^ b;
            default: begin
                exp_value = '0;
                exp_reg = '0;
                exp_mis = ((a == b) != r.predict); // Taken means the sources are equal.
            end
        endcase
        check_value(names[idx], "retire_reg", xlen'(exp_reg), xlen'(retire_reg));
        check_value(names[idx], "retire_value", exp_value, retire_value);
        check_value(names[idx], "squash", xlen'(exp_mis), xlen'(squash));
        if (exp_reg != '0) model_regs[exp_reg] = exp_value;
        retired++;
        $display("%s %s: r%0d = 0x%08h", names[idx], (errors == errors_before) ? "done" : "failed",
                 retire_reg, retire_value);
        if (exp_mis) begin
            while (pending.size() != 0) begin
                idx = pending.pop_front();
                squashed++;
                $display("%s squashed as expected", names[idx]);
            end
        end
    endtask

    task automatic dispatch_row(input int idx);
        int idle;
        dispatch_enable = 1'b0;
        if (rows[idx].paced) begin
            idle = draw_bits(2);
            repeat (idle) begin
                @(posedge clock);
                #1;
            end
        end
        while (dispatch_stall) begin
            if (!squash) stall_cycles++;
            @(posedge clock);
            #1;
        end
        op = rows[idx].op;
        dest_reg = rows[idx].dest;
        src_reg1 = rows[idx].src1;
        src_reg2 = rows[idx].src2;
        predict_taken = rows[idx].predict;
        dispatch_enable = 1'b1;
        pending.push_back(idx);
        @(posedge clock);
        #1;
    endtask

    // Retire outputs are sampled mid-cycle, away from the drive edge.
    initial begin
        @(negedge reset);
        forever begin
            @(negedge clock);
            if (retire_valid) begin
                retire_events++;
                check_retire();
            end else begin
                assert (!squash) else begin
                    $display("squash raised with no instruction retiring");
                    errors++;
                end
            end
        end
    end

    initial begin
        @(negedge reset);
        repeat (rows.size() * 20) @(posedge clock);
        $display("Timeout: instructions still outstanding after %0d cycles", rows.size() * 20);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset = 1'b1;
        dispatch_enable = 1'b0;
        op = op_add;
        dest_reg = '0;
        src_reg1 = '0;
        src_reg2 = '0;
        predict_taken = 1'b0;
        for (int i = 0; i < reg_count; i++) model_regs[i] = xlen'(i);
        add_row("add_indep", op_add, 3, 1, 2, 0, 1);
        add_row("sub_indep", op_sub, 4, 9, 5, 0, 1);
        add_row("xor_indep", op_xor, 5, 6, 7, 0, 1);
        add_row("raw_first", op_add, 6, 3, 4, 0, 0);
        add_row("raw_rewrite", op_add, 6, 6, 6, 0, 0);
        add_row("raw_sub", op_sub, 7, 6, 5, 0, 1);
        add_row("write_r0", op_add, 0, 8, 9, 0, 1);
        add_row("read_r0", op_add, 8, 0, 2, 0, 0);
        add_row("branch_hit", op_branch, 0, 1, 1, 1, 1);
        add_row("after_hit", op_xor, 9, 6, 8, 0, 0);
        add_row("branch_miss", op_branch, 0, 3, 4, 1, 1);
        add_row("shadow_a", op_add, 10, 1, 2, 0, 0);
        add_row("shadow_b", op_sub, 11, 10, 1, 0, 0);
        add_row("post_squash", op_add, 12, 10, 11, 0, 1);
        add_row("chain_1", op_add, 13, 12, 1, 0, 1);
        add_row("chain_2", op_add, 13, 13, 13, 0, 0);
        add_row("chain_3", op_add, 13, 13, 13, 0, 0);
        add_row("chain_4", op_sub, 14, 13, 2, 0, 0);
        add_row("burst_1", op_xor, 15, 14, 13, 0, 0);
        add_row("burst_2", op_add, 16, 15, 1, 0, 0);
        add_row("burst_3", op_add, 17, 16, 17, 0, 0);
        add_row("burst_4", op_xor, 18, 3, 4, 0, 0);
        add_row("burst_5", op_add, 19, 18, 19, 0, 0);
        add_row("branch_end", op_branch, 0, 5, 5, 1, 0);
        add_row("burst_tail", op_add, 20, 19, 0, 0, 0);
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
        assert (!retire_valid && !squash && !dispatch_stall) else begin
            $display("Core outputs are not idle after reset");
            errors++;
        end
        for (int i = 0; i < rows.size(); i++) begin
            dispatch_row(i);
        end
        dispatch_enable = 1'b0;
        while (pending.size() != 0) @(posedge clock);
        repeat (4) @(posedge clock);  // A stray retire here is caught by the monitor.
        assert (stall_cycles > 0) else begin
            $display("dispatch_stall never rose for a full buffer during the burst");
            errors++;
        end
        assert (squashed > 0) else begin
            $display("The mispredicted branch squashed no younger instruction");
            errors++;
        end
        check_value("instruction_count", "retires seen", xlen'(rows.size() - squashed),
                    xlen'(retire_events));
        $display("Summary: %0d rows, %0d retired, %0d squashed, %0d stall cycles, %0d errors",
                 rows.size(), retired, squashed, stall_cycles, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
